// ==== Makefile ====
# Verilator build and run for the HUB75 panel driver testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tbHub75
FILELIST  := project.f
BUILDDIR  := obj_dir
LOG       := sim.log
FAILMSG   := Finished with errors

SOURCES := $(shell grep -v '^+' $(FILELIST)) verilog/panel_cfg.svh
SIMBIN  := $(BUILDDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIMBIN)

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qx "$(FAILMSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== project.f ====
+incdir+verilog
verilog/panelPkg.sv
verilog/frameBuffer.sv
verilog/fm6126Init.sv
verilog/rowScanner.sv
verilog/panelOutMux.sv
verilog/hub75Top.sv
sim/tbHub75.sv

// ==== sim/tbHub75.sv ====
// testbench for the HUB75 panel driver
// checks the FM6126A register load, frame scan-out against a model
// and a single pixel update between two frames
`timescale 1ns/1ps
`include "panel_cfg.svh"

module tbHub75;

    // FM6126A words and latch lengths the panel expects at start-up
    localparam logic [15:0] expReg12 = 16'h7FFF;
    localparam logic [15:0] expReg13 = 16'h0040;
    localparam int expLatch12 = 12;
    localparam int expLatch13 = 13;
    // register 12 and register 13 each take one full row of clocked pixels
    localparam int initPixels = 2 * `PANEL_WIDTH;
    // three cycles per pixel, then blank, latch and the lit interval
    localparam int rowCycles = 3 * `PANEL_WIDTH + 2 + `DISPLAY_CYCLES;
    localparam int frameCycles = `SCAN_ROWS * rowCycles;
    // init, one host write per pixel, up to three frames of scanning and some margin
    localparam int timeoutLimit =
        300 + `PANEL_WIDTH * `PANEL_HEIGHT + 3 * frameCycles + 2000;

    logic              clk_in;
    logic              reset;
    logic              wrEn;
    panelPkg::pixAddrT wrAddr;
    panelPkg::colorT   wrData;
    panelPkg::colorT   rgb1;
    panelPkg::colorT   rgb2;
    logic              pixClock;
    logic              latch;
    logic              oeN;
    panelPkg::scanRowT rowAddr;

    // pin values captured at every rising pixel clock
    panelPkg::colorT capRgb1 [$];
    panelPkg::colorT capRgb2 [$];
    logic            capLatch [$];
    // row address and number of captured pixels at each scan latch pulse
    panelPkg::scanRowT latchRows [$];
    int                latchPixCount [$];
    // expected frame buffer contents
    panelPkg::colorT model [`PANEL_HEIGHT][`PANEL_WIDTH];

    logic [31:0]       rngState;
    int                valueErrors = 0;
    int                otherErrors = 0;
    int                cycleCount = 0;
    logic              lastPixClock = 1'b0;
    logic              lastLatch = 1'b0;
    panelPkg::scanRowT nextRow;

    hub75Top uut (
        .clk_in(clk_in), .reset(reset), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rgb1(rgb1), .rgb2(rgb2), .pixClock(pixClock), .latch(latch), .oeN(oeN),
        .rowAddr(rowAddr)
    );

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    // xorshift32 generator for frame data
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic reportMismatch(input string what);
        valueErrors++;
        $display("[FAIL] %0t: %s", $time, what);
    endtask

    task automatic reportProblem(input string what);
        otherErrors++;
        $display("error: %s", what);
    endtask

    // pins are registered on the rising clock, so mid-cycle they are settled
    always @(negedge clk_in) begin
        if (!reset) begin
            // the load patterns must never light the panel
            if (capRgb1.size() < initPixels) begin
                assert (oeN == 1'b1) else reportMismatch("oeN went low during init");
            end
            assert (!latch || oeN) else reportMismatch("latch high while oeN is low");
            if (pixClock && !lastPixClock) begin
                capRgb1.push_back(rgb1);
                capRgb2.push_back(rgb2);
                capLatch.push_back(latch);
            end
            // both init latches rise before pixel 128, every later one belongs to the scan
            if (latch && !lastLatch && capRgb1.size() >= initPixels) begin
                if (latchRows.size() == 0) begin
                    nextRow = 4'd0;
                end else if (latchRows[$] == 4'(`SCAN_ROWS - 1)) begin
                    nextRow = 4'd0;
                end else begin
                    nextRow = latchRows[$] + 4'd1;
                end
                assert (rowAddr == nextRow) else reportMismatch($sformatf(
                    "latch rowAddr %0d, expected %0d", rowAddr, nextRow));
                latchRows.push_back(rowAddr);
                latchPixCount.push_back(capRgb1.size());
            end
        end
        lastPixClock = pixClock;
        lastLatch = latch;
    end

    task automatic applyReset();
        reset = 1'b1;
        repeat (4) @(posedge clk_in);
        #2;
        reset = 1'b0;
    endtask

    // behavior 1, quiet pins between reset and the first shifted pixel
    task automatic checkIdleAfterReset();
        int waited;
        logic seenShift;
        waited = 0;
        seenShift = 1'b0;
        while (!seenShift && waited < 64) begin
            @(negedge clk_in);
            if (pixClock) begin
                seenShift = 1'b1;
            end else begin
                assert (latch == 1'b0) else reportMismatch("latch high before the first shift");
                assert (oeN == 1'b1) else reportMismatch("oeN low before the first shift");
                waited++;
            end
        end
        if (!seenShift) begin
            reportProblem("pixel clock did not start within 64 cycles after reset");
        end
    endtask

    // behaviors 2 and 3, register 12 then register 13 on all six colour lines
    task automatic checkInitSequence();
        int i;
        int pos;
        int latchLen;
        logic [15:0] word;
        panelPkg::colorT expColor;
        logic expLatchBit;
        while (capRgb1.size() < initPixels) begin
            @(posedge clk_in);
            #2;
        end
        for (i = 0; i < initPixels; i++) begin
            word = (i < `PANEL_WIDTH) ? expReg12 : expReg13;
            latchLen = (i < `PANEL_WIDTH) ? expLatch12 : expLatch13;
            pos = i % `PANEL_WIDTH;
            expColor = {3{word[i % 16]}};
            // latch is high on the last latchLen pixels of each word
            expLatchBit = (pos >= `PANEL_WIDTH - latchLen);
            assert (capRgb1[i] == expColor) else reportMismatch($sformatf(
                "init pixel %0d rgb1 %b, expected %b", i, capRgb1[i], expColor));
            assert (capRgb2[i] == expColor) else reportMismatch($sformatf(
                "init pixel %0d rgb2 %b, expected %b", i, capRgb2[i], expColor));
            assert (capLatch[i] == expLatchBit) else reportMismatch($sformatf(
                "init pixel %0d latch %b, expected %b", i, capLatch[i], expLatchBit));
        end
        $display("init sequence checked");
    endtask

    task automatic writePixel(input int row, input int col, input panelPkg::colorT data);
        @(posedge clk_in);
        #2;
        wrEn = 1'b1;
        wrAddr = {5'(row), 6'(col)};
        wrData = data;
        model[row][col] = data;
    endtask

    task automatic releaseWrite();
        @(posedge clk_in);
        #2;
        wrEn = 1'b0;
    endtask

    task automatic fillRandomFrame();
        int row;
        int col;
        for (row = 0; row < `PANEL_HEIGHT; row++) begin
            for (col = 0; col < `PANEL_WIDTH; col++) begin
                rngState = xorshift(rngState);
                writePixel(row, col, rngState[2:0]);
            end
        end
        releaseWrite();
    endtask

    // a frame opens after the latch of scan row 15
    task automatic waitFrameStart();
        int seen;
        seen = latchRows.size();
        while (!(latchRows.size() > seen && latchRows[$] == 4'(`SCAN_ROWS - 1))) begin
            @(posedge clk_in);
            #2;
        end
    endtask

    // behaviors 4 and 5, one whole frame of captured pixels and latches against the model
    task automatic checkFrame(input string label);
        int pixBase;
        int latchBase;
        int r;
        int i;
        int idx;
        pixBase = capRgb1.size();
        latchBase = latchRows.size();
        if (latchBase == 0) begin
            reportProblem($sformatf("%s: no scan latch was seen before the frame", label));
        end else if (latchRows[$] != 4'(`SCAN_ROWS - 1) || latchPixCount[$] != pixBase) begin
            reportProblem($sformatf("%s: capture did not start on a frame boundary", label));
        end
        while (latchRows.size() < latchBase + `SCAN_ROWS) begin
            @(posedge clk_in);
            #2;
        end
        for (r = 0; r < `SCAN_ROWS; r++) begin
            assert (latchRows[latchBase + r] == 4'(r)) else reportMismatch($sformatf(
                "%s: latch %0d rowAddr %0d", label, r, latchRows[latchBase + r]));
            // exactly one row of pixels is shifted before each latch
            assert (latchPixCount[latchBase + r] == pixBase + `PANEL_WIDTH * (r + 1))
                else reportMismatch($sformatf("%s: row %0d shifted %0d pixels in total",
                    label, r, latchPixCount[latchBase + r] - pixBase));
            for (i = 0; i < `PANEL_WIDTH; i++) begin
                idx = pixBase + `PANEL_WIDTH * r + i;
                assert (capRgb1[idx] == model[r][i]) else reportMismatch($sformatf(
                    "%s: row %0d col %0d rgb1 %b, expected %b",
                    label, r, i, capRgb1[idx], model[r][i]));
                assert (capRgb2[idx] == model[r + `SCAN_ROWS][i]) else reportMismatch(
                    $sformatf("%s: row %0d col %0d rgb2 %b, expected %b", label,
                    r + `SCAN_ROWS, i, capRgb2[idx], model[r + `SCAN_ROWS][i]));
            end
        end
        $display("%s checked", label);
    endtask

    // behavior 6, lands during the row 15 lit interval, before the next frame reads
    task automatic rewriteOnePixel();
        int row;
        int col;
        panelPkg::colorT flip;
        rngState = xorshift(rngState);
        row = int'(rngState[20:16]);
        col = int'(rngState[13:8]);
        // a nonzero flip guarantees the pixel really changes
        flip = (rngState[2:0] == 3'b000) ? 3'b111 : rngState[2:0];
        $display("rewriting row %0d column %0d", row, col);
        writePixel(row, col, model[row][col] ^ flip);
        releaseWrite();
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        reset = 1'b1;
        wrEn = 1'b0;
        wrAddr = '0;
        wrData = '0;
        rngState = 32'h89e8897f;
        applyReset();
        checkIdleAfterReset();
        checkInitSequence();
        fillRandomFrame();
        waitFrameStart();
        checkFrame("random frame");
        rewriteOnePixel();
        checkFrame("frame after single pixel rewrite");
        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // ends a run that stalls, for example when the scanner never reaches row 15
    initial begin
        while (cycleCount < timeoutLimit) begin
            @(posedge clk_in);
            cycleCount++;
        end
        $display("error: timeout after %0d cycles, the tests did not complete", cycleCount);
        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors + 1);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== verilog/fm6126Init.sv ====
// FM6126A start-up sequencer
// shifts the register 12 and register 13 words through the column drivers
// and pulses initDone once the panel is ready for pixel data
`timescale 1ns/1ps
`include "panel_cfg.svh"

module fm6126Init (
    input  logic            clk_in,
    input  logic            reset,
    output panelPkg::colorT initRgb1,
    output panelPkg::colorT initRgb2,
    output logic            initLatch,
    output logic            initClock,
    output logic            initBusy,
    output logic            initDone
);

    // current step of the load sequence
    panelPkg::initStateT state;
    // position inside the 64 pixel register word, wraps back to 0 after each word
    panelPkg::colAddrT pixCount;
    // pixels still to go before latch rises, stays at zero once reached
    logic [6:0] latchCount;
    // configuration word of the register being shifted
    logic [15:0] regWord;
    // bit presented on all six colour lines for the current pixel
    logic shiftBit;

    // the word is only read in the data states, so register 12 is the default
    assign regWord = (state == panelPkg::reg13Data) ? `INIT_REG13 : `INIT_REG12;
    // the 16 bit word repeats four times across the 64 columns
    assign shiftBit = regWord[pixCount[3:0]];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state      <= panelPkg::initStart;
            pixCount   <= '0;
            latchCount <= '0;
            initRgb1   <= '0;
            initRgb2   <= '0;
            initLatch  <= 1'b0;
            initClock  <= 1'b0;
            initBusy   <= 1'b0;
            initDone   <= 1'b0;
        end else begin
            // done is a single cycle strobe
            initDone <= 1'b0;
            case (state)
                panelPkg::initStart: begin
                    // latch rises for the last INIT_LATCH12 pixels of register 12
                    initBusy   <= 1'b1;
                    pixCount   <= '0;
                    latchCount <= 7'(`PANEL_WIDTH - `INIT_LATCH12);
                    state      <= panelPkg::reg12Data;
                end
                panelPkg::reg12Data, panelPkg::reg13Data: begin
                    // present data with the clock low, latch is set here and nowhere else
                    initRgb1  <= {3{shiftBit}};
                    initRgb2  <= {3{shiftBit}};
                    initLatch <= (latchCount == '0);
                    initClock <= 1'b0;
                    if (state == panelPkg::reg12Data) begin
                        state <= panelPkg::reg12Clock;
                    end else begin
                        state <= panelPkg::reg13Clock;
                    end
                end
                panelPkg::reg12Clock, panelPkg::reg13Clock: begin
                    // rising pixel clock shifts the bit into the drivers
                    initClock <= 1'b1;
                    pixCount  <= pixCount + 1'b1;
                    if (latchCount != '0) begin
                        latchCount <= latchCount - 1'b1;
                    end
                    if (pixCount != 6'(`PANEL_WIDTH - 1)) begin
                        state <= (state == panelPkg::reg12Clock) ?
                                 panelPkg::reg12Data : panelPkg::reg13Data;
                    end else if (state == panelPkg::reg12Clock) begin
                        // register 13 starts with latch low, which ends the register 12 latch
                        latchCount <= 7'(`PANEL_WIDTH - `INIT_LATCH13);
                        state      <= panelPkg::reg13Data;
                    end else begin
                        state <= panelPkg::initFinish;
                    end
                end
                panelPkg::initFinish: begin
                    // park the lines low and hand over to the scanner
                    initClock <= 1'b0;
                    initLatch <= 1'b0;
                    initBusy  <= 1'b0;
                    initDone  <= 1'b1;
                    state     <= panelPkg::initIdle;
                end
                default: begin
                    // nothing more to do until the next reset
                    state <= panelPkg::initIdle;
                end
            endcase
        end
    end

    // the drivers sample latch on the clock edge, so it must hold while the clock is high
    latchStableOnClock: assert property (
        @(posedge clk_in) disable iff (reset) initClock |-> $stable(initLatch)
    );

endmodule

// ==== verilog/frameBuffer.sv ====
// pixel memory for the 64x32 panel
// one bit per colour, host write port and a registered read of both scan halves
`timescale 1ns/1ps
`include "panel_cfg.svh"

module frameBuffer (
    input  logic              clk_in,
    input  logic              wrEn,
    input  panelPkg::pixAddrT wrAddr,
    input  panelPkg::colorT   wrData,
    input  panelPkg::scanRowT rdRow,
    input  panelPkg::colAddrT rdCol,
    output panelPkg::colorT   topPixel,
    output panelPkg::colorT   bottomPixel
);

    // the halves live in separate arrays so one read returns both rows of a scan pair
    panelPkg::colorT topHalf    [(`PANEL_HEIGHT / 2) * `PANEL_WIDTH];
    panelPkg::colorT bottomHalf [(`PANEL_HEIGHT / 2) * `PANEL_WIDTH];

    // row within the half and column, shared layout for both arrays
    logic [9:0] wrIndex;
    logic [9:0] rdIndex;
    // top row bit picks the lower half of the panel
    logic wrBottom;

    assign wrIndex  = wrAddr[9:0];
    assign wrBottom = wrAddr[10];
    assign rdIndex  = {rdRow, rdCol};

    // host writes land on the next clock
    always_ff @(posedge clk_in) begin
        if (wrEn) begin
            if (wrBottom) begin
                bottomHalf[wrIndex] <= wrData;
            end else begin
                topHalf[wrIndex] <= wrData;
            end
        end
    end

    // both halves come back one cycle after the address
    always_ff @(posedge clk_in) begin
        topPixel    <= topHalf[rdIndex];
        bottomPixel <= bottomHalf[rdIndex];
    end

endmodule

// ==== verilog/hub75Top.sv ====
// HUB75 panel driver top level
// frame buffer, FM6126A start-up, row scanner and pin selection
`timescale 1ns/1ps

module hub75Top (
    input  logic              clk_in,
    input  logic              reset,
    input  logic              wrEn,
    input  panelPkg::pixAddrT wrAddr,
    input  panelPkg::colorT   wrData,
    output panelPkg::colorT   rgb1,
    output panelPkg::colorT   rgb2,
    output logic              pixClock,
    output logic              latch,
    output logic              oeN,
    output panelPkg::scanRowT rowAddr
);

    // buffer read path
    panelPkg::scanRowT rdRow;
    panelPkg::colAddrT rdCol;
    panelPkg::colorT   topPixel;
    panelPkg::colorT   bottomPixel;

    // init stage pins and handover
    panelPkg::colorT initRgb1;
    panelPkg::colorT initRgb2;
    logic            initLatch;
    logic            initClock;
    logic            initBusy;
    logic            initDone;

    // scanner pins
    panelPkg::colorT   scanRgb1;
    panelPkg::colorT   scanRgb2;
    logic              scanLatch;
    logic              scanClock;
    logic              scanOeN;
    panelPkg::scanRowT scanRow;

    frameBuffer fb (
        .clk_in(clk_in), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdRow(rdRow), .rdCol(rdCol), .topPixel(topPixel), .bottomPixel(bottomPixel)
    );

    fm6126Init initStage (
        .clk_in(clk_in), .reset(reset), .initRgb1(initRgb1), .initRgb2(initRgb2),
        .initLatch(initLatch), .initClock(initClock), .initBusy(initBusy),
        .initDone(initDone)
    );

    rowScanner scanner (
        .clk_in(clk_in), .reset(reset), .initDone(initDone), .topPixel(topPixel),
        .bottomPixel(bottomPixel), .rdRow(rdRow), .rdCol(rdCol), .scanRgb1(scanRgb1),
        .scanRgb2(scanRgb2), .scanLatch(scanLatch), .scanClock(scanClock),
        .scanOeN(scanOeN), .scanRow(scanRow)
    );

    panelOutMux outMux (
        .clk_in(clk_in), .reset(reset), .initBusy(initBusy), .initRgb1(initRgb1),
        .initRgb2(initRgb2), .initLatch(initLatch), .initClock(initClock),
        .scanRgb1(scanRgb1), .scanRgb2(scanRgb2), .scanLatch(scanLatch),
        .scanClock(scanClock), .scanOeN(scanOeN), .scanRow(scanRow),
        .rgb1(rgb1), .rgb2(rgb2), .pixClock(pixClock), .latch(latch),
        .oeN(oeN), .rowAddr(rowAddr)
    );

endmodule

// ==== verilog/panelOutMux.sv ====
// panel pin selector
// registers the init stage onto the pins until the FM6126A load has finished,
// then the row scanner, keeping the panel dark before the handover
`timescale 1ns/1ps

module panelOutMux (
    input  logic              clk_in,
    input  logic              reset,
    input  logic              initBusy,
    input  panelPkg::colorT   initRgb1,
    input  panelPkg::colorT   initRgb2,
    input  logic              initLatch,
    input  logic              initClock,
    input  panelPkg::colorT   scanRgb1,
    input  panelPkg::colorT   scanRgb2,
    input  logic              scanLatch,
    input  logic              scanClock,
    input  logic              scanOeN,
    input  panelPkg::scanRowT scanRow,
    output panelPkg::colorT   rgb1,
    output panelPkg::colorT   rgb2,
    output logic              pixClock,
    output logic              latch,
    output logic              oeN,
    output panelPkg::scanRowT rowAddr
);

    // init has been seen running since reset
    logic sawBusy;
    // sticky, pins follow the scanner from here on
    logic scanActive;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            sawBusy    <= 1'b0;
            scanActive <= 1'b0;
            rgb1       <= '0;
            rgb2       <= '0;
            pixClock   <= 1'b0;
            latch      <= 1'b0;
            oeN        <= 1'b1;
            rowAddr    <= '0;
        end else begin
            if (initBusy) begin
                sawBusy <= 1'b1;
            end
            // busy falling after having been high marks the end of the register load
            if (sawBusy && !initBusy) begin
                scanActive <= 1'b1;
            end
            if (scanActive) begin
                rgb1     <= scanRgb1;
                rgb2     <= scanRgb2;
                pixClock <= scanClock;
                latch    <= scanLatch;
                oeN      <= scanOeN;
                rowAddr  <= scanRow;
            end else begin
                // the load patterns must not light the LEDs
                rgb1     <= initRgb1;
                rgb2     <= initRgb2;
                pixClock <= initClock;
                latch    <= initLatch;
                oeN      <= 1'b1;
                rowAddr  <= '0;
            end
        end
    end

endmodule

// ==== verilog/panelPkg.sv ====
// HUB75 panel types
// vector widths shared between the stages and the state encodings of both FSMs
package panelPkg;

    // one pixel, red in bit 2, green in bit 1, blue in bit 0
    typedef logic [2:0] colorT;
    // column index inside a row
    typedef logic [5:0] colAddrT;
    // scan row index, also drives the panel row address lines
    typedef logic [3:0] scanRowT;
    // host write address, row in bits 10:6 and column in bits 5:0
    typedef logic [10:0] pixAddrT;

    // FM6126A register load sequence
    typedef enum logic [2:0] {
        initStart, reg12Data, reg12Clock, reg13Data, reg13Clock, initFinish, initIdle
    } initStateT;

    // row scan sequence
    typedef enum logic [2:0] {
        waitInit, readPixel, shiftData, shiftClock, blankRow, latchRow, showRow
    } scanStateT;

endpackage

// ==== verilog/panel_cfg.svh ====
// HUB75 panel configuration
// geometry, FM6126A start-up register words and row display timing
`ifndef PANEL_CFG_SVH
`define PANEL_CFG_SVH

// 64x32 panel driven with 1/16 scan
`define PANEL_WIDTH 64
`define PANEL_HEIGHT 32
// upper row r is shown together with lower row r+16
`define SCAN_ROWS 16

// FM6126A configuration words for registers 12 and 13
`define INIT_REG12 16'h7FFF
`define INIT_REG13 16'h0040
// the register number is given by how many final pixels see latch high
`define INIT_LATCH12 12
`define INIT_LATCH13 13

// clock cycles each scan row stays lit
`define DISPLAY_CYCLES 64

`endif

// ==== verilog/rowScanner.sv ====
// HUB75 row scanner
// shifts the 64 pixel pairs of each scan row, then blanks, latches,
// selects the row and holds it lit for DISPLAY_CYCLES clocks
`timescale 1ns/1ps
`include "panel_cfg.svh"

module rowScanner (
    input  logic              clk_in,
    input  logic              reset,
    input  logic              initDone,
    input  panelPkg::colorT   topPixel,
    input  panelPkg::colorT   bottomPixel,
    output panelPkg::scanRowT rdRow,
    output panelPkg::colAddrT rdCol,
    output panelPkg::colorT   scanRgb1,
    output panelPkg::colorT   scanRgb2,
    output logic              scanLatch,
    output logic              scanClock,
    output logic              scanOeN,
    output panelPkg::scanRowT scanRow
);

    panelPkg::scanStateT state;
    // column being shifted, counts up from 0
    panelPkg::colAddrT colCnt;
    // scan row being shifted and then shown
    panelPkg::scanRowT rowCnt;
    // cycles of the lit interval still remaining
    logic [7:0] showTimer;

    // frame buffer address follows the counters directly
    assign rdRow = rowCnt;
    assign rdCol = colCnt;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state     <= panelPkg::waitInit;
            colCnt    <= '0;
            rowCnt    <= '0;
            showTimer <= '0;
            scanLatch <= 1'b0;
            scanClock <= 1'b0;
            scanOeN   <= 1'b1;
            scanRow   <= '0;
        end else begin
            case (state)
                panelPkg::waitInit: begin
                    // the drivers ignore pixel data until their registers are loaded
                    scanOeN <= 1'b1;
                    if (initDone) begin
                        state <= panelPkg::readPixel;
                    end
                end
                panelPkg::readPixel: begin
                    // address is on the buffer now, pixel pair arrives next cycle
                    scanClock <= 1'b0;
                    scanOeN   <= 1'b1;
                    state     <= panelPkg::shiftData;
                end
                panelPkg::shiftData: begin
                    // set up the pair with the clock still low
                    scanRgb1 <= topPixel;
                    scanRgb2 <= bottomPixel;
                    state    <= panelPkg::shiftClock;
                end
                panelPkg::shiftClock: begin
                    scanClock <= 1'b1;
                    colCnt    <= colCnt + 1'b1;
                    if (colCnt == 6'(`PANEL_WIDTH - 1)) begin
                        state <= panelPkg::blankRow;
                    end else begin
                        state <= panelPkg::readPixel;
                    end
                end
                panelPkg::blankRow: begin
                    // one dark cycle before the latch so the old row is not smeared
                    scanClock <= 1'b0;
                    scanOeN   <= 1'b1;
                    state     <= panelPkg::latchRow;
                end
                panelPkg::latchRow: begin
                    // transfer the shifted row and move the row lines while still dark
                    scanLatch <= 1'b1;
                    scanRow   <= rowCnt;
                    showTimer <= 8'(`DISPLAY_CYCLES - 1);
                    state     <= panelPkg::showRow;
                end
                panelPkg::showRow: begin
                    scanLatch <= 1'b0;
                    scanOeN   <= 1'b0;
                    if (showTimer == '0) begin
                        // blanking comes back with the first read of the next row
                        if (rowCnt == 4'(`SCAN_ROWS - 1)) begin
                            rowCnt <= '0;
                        end else begin
                            rowCnt <= rowCnt + 1'b1;
                        end
                        state <= panelPkg::readPixel;
                    end else begin
                        showTimer <= showTimer - 1'b1;
                    end
                end
                default: begin
                    state <= panelPkg::waitInit;
                end
            endcase
        end
    end

    // a latch pulse always falls inside a blanked stretch that began before it
    latchWhileBlanked: assert property (
        @(posedge clk_in) disable iff (reset) scanLatch |-> scanOeN && $past(scanOeN)
    );

endmodule
